/* logic/desc_pkg.sv */
/*
 * Descriptor-side definitions shared by the request generator datapath.
 * Holds the default descriptor count, the fetch FSM state encoding and
 * the index width helper. Modules size ports with scoped names and
 * import the package in their body when they need it there.
 */

`default_nettype none

package desc_pkg;

   ////////////////////////////////
   // descriptor count
   ////////////////////////////////

   // number of descriptors owned by software
   localparam int default_max_desc = 8;

   ////////////////////////////////
   // fetch FSM
   ////////////////////////////////

   // idle waits for an id
   // read waits for aznext
   typedef enum logic {
      fetch_idle = 1'b0,
      fetch_read = 1'b1
   } fetch_state_t;

   ////////////////////////////////
   // helpers
   ////////////////////////////////

   // index width for n descriptors
   // one bit at least
   function automatic int desc_idx_w(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

endpackage

`default_nettype wire

/* logic/wb_regs_pkg.sv */
/*
 * Register map of the Wishbone order-table block.
 * Order entries live at addresses 0 to max_desc-1, the control
 * register sits at reg_ctrl_adr. The data word is decoded either as
 * an order entry or as the control word, depending on the address.
 */

`default_nettype none

package wb_regs_pkg;

   ////////////////////////////////
   // bus geometry
   ////////////////////////////////

   localparam int wb_data_w = 8;
   localparam int wb_adr_w  = 5;

   // control register address
   localparam logic [wb_adr_w-1:0] reg_ctrl_adr = 5'd16;

   // descriptor index field in an entry word
   localparam int entry_idx_w = 3;

   ////////////////////////////////
   // register word
   ////////////////////////////////

   // same 8 bits, two readings
   typedef union packed {
      // order entry, valid in the top bit
      struct packed {
         logic                               valid;
         logic [wb_data_w-entry_idx_w-2:0]   rsvd;
         logic [entry_idx_w-1:0]             idx;
      } entry;
      // control word
      struct packed {
         logic [wb_data_w-3:0]   rsvd;
         logic                   push;
         logic                   auto_mode;
      } ctrl;
   } reg_word_u;

endpackage

`default_nettype wire

/* logic/grant_serializer.sv */
/*
 * Serializes a vector of request pulses into one grant per cycle.
 * New pulses collect in a pending vector and the lowest pending bit
 * is granted and cleared each cycle, starting the cycle after a pulse.
 */

`default_nettype none

module grant_serializer #(
   parameter int max_desc = desc_pkg::default_max_desc
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic [max_desc-1:0]                        req,
   output logic                                       gnt_vld,
   output logic [desc_pkg::desc_idx_w(max_desc)-1:0]  gnt_idx
);
   import desc_pkg::*;

   localparam int iw = desc_idx_w(max_desc);

   logic [max_desc-1:0] pend;
   logic [max_desc-1:0] pend_nxt;

   // lowest set bit wins
   always_comb begin
      gnt_idx = '0;
      for (int i = max_desc - 1; i >= 0; i--) begin
         if (pend[i]) begin
            gnt_idx = iw'(i);
         end
      end
   end

   assign gnt_vld = |pend;

   // drop the granted bit and merge new pulses
   always_comb begin
      pend_nxt = pend;
      if (gnt_vld) begin
         pend_nxt[gnt_idx] = 1'b0;
      end
      pend_nxt = pend_nxt | req;
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         pend <= '0;
      end else begin
         pend <= pend_nxt;
      end
   end

endmodule

`default_nettype wire

/* logic/desc_fifo.sv */
/*
 * Synchronous FIFO of descriptor indices.
 * head shows the oldest entry without popping, rd_data is registered
 * on a pop. Writes when full are dropped and reads when empty ignored.
 */

`default_nettype none

module desc_fifo #(
   parameter int max_desc = desc_pkg::default_max_desc,
   parameter int depth    = desc_pkg::default_max_desc
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic                                       wr_en,
   input  logic [desc_pkg::desc_idx_w(max_desc)-1:0]  wr_data,
   input  logic                                       rd_en,
   output logic [desc_pkg::desc_idx_w(max_desc)-1:0]  rd_data,
   output logic [desc_pkg::desc_idx_w(max_desc)-1:0]  head,
   output logic                                       head_valid,
   output logic                                       empty
);
   import desc_pkg::*;

   localparam int iw = desc_idx_w(max_desc);
   localparam int pw = desc_idx_w(depth);
   localparam int cw = $clog2(depth + 1);

   logic [iw-1:0]   mem [depth];
   logic [pw-1:0]   wr_ptr;
   logic [pw-1:0]   rd_ptr;
   logic [cw-1:0]   count;
   logic            full;
   logic            do_wr;
   logic            do_rd;

   assign full  = (count == cw'(depth));
   assign empty = (count == '0);
   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   // oldest entry, seen one cycle after its write
   assign head       = mem[rd_ptr];
   assign head_valid = ~empty;

   //////////////////////////////
   // pointers and occupancy
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == pw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == pw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + cw'(do_wr) - cw'(do_rd);
      end
   end

   // storage and read register
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
      if (do_rd) begin
         rd_data <= mem[rd_ptr];
      end
   end

endmodule

`default_nettype wire

/* logic/order_regs.sv */
/*
 * Wishbone classic slave for the software order table.
 * Holds one entry per table slot plus the mode bit. Writing the
 * control register with push set sends the valid slots, lowest slot
 * first, into the order FIFO at one index per cycle.
 */

`default_nettype none

module order_regs #(
   parameter int max_desc = desc_pkg::default_max_desc
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic                                       wb_cyc,
   input  logic                                       wb_stb,
   input  logic                                       wb_we,
   input  logic [wb_regs_pkg::wb_adr_w-1:0]           wb_adr,
   input  wb_regs_pkg::reg_word_u                     wb_dat_w,
   output wb_regs_pkg::reg_word_u                     wb_dat_r,
   output logic                                       wb_ack,
   output logic                                       auto_mode,
   output logic                                       order_wr_en,
   output logic [desc_pkg::desc_idx_w(max_desc)-1:0]  order_wr_idx
);
   import desc_pkg::*;
   import wb_regs_pkg::*;

   localparam int iw = desc_idx_w(max_desc);

   logic [max_desc-1:0]   tbl_valid;
   logic [iw-1:0]         tbl_idx [max_desc];
   logic                  is_slot;
   logic                  is_ctrl;
   logic                  wr_hit;
   logic [iw-1:0]         slot;
   logic [max_desc-1:0]   push_req;
   logic                  gnt_vld;
   logic [iw-1:0]         gnt_idx;

   // address decode
   assign is_slot = (wb_adr < wb_adr_w'(max_desc));
   assign is_ctrl = (wb_adr == reg_ctrl_adr);
   assign slot    = wb_adr[iw-1:0];

   // write lands on the ack cycle
   assign wr_hit  = wb_ack & wb_cyc & wb_stb & wb_we;

   //////////////////////////////
   // bus handshake and storage
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wb_ack    <= 1'b0;
         auto_mode <= 1'b0;
         tbl_valid <= '0;
         for (int i = 0; i < max_desc; i++) begin
            tbl_idx[i] <= '0;
         end
      end else begin
         // single cycle ack pulse per access
         wb_ack <= wb_cyc & wb_stb & ~wb_ack;
         if (wr_hit && is_slot) begin
            tbl_valid[slot] <= wb_dat_w.entry.valid;
            tbl_idx[slot]   <= iw'(wb_dat_w.entry.idx);
         end
         if (wr_hit && is_ctrl) begin
            auto_mode <= wb_dat_w.ctrl.auto_mode;
         end
      end
   end

   // read mux
   // push is a trigger only and reads as zero
   always_comb begin
      wb_dat_r = '0;
      if (is_slot) begin
         wb_dat_r.entry.valid = tbl_valid[slot];
         wb_dat_r.entry.idx   = entry_idx_w'(tbl_idx[slot]);
      end else if (is_ctrl) begin
         wb_dat_r.ctrl.auto_mode = auto_mode;
      end
   end

   //////////////////////////////
   // push into order FIFO
   //////////////////////////////

   // one pulse of all valid slots
   assign push_req = (wr_hit && is_ctrl && wb_dat_w.ctrl.push) ? tbl_valid : '0;

   grant_serializer #(
      .max_desc (max_desc)
   ) u_push_ser (
      .clk     (clk),
      .resetn  (resetn),
      .req     (push_req),
      .gnt_vld (gnt_vld),
      .gnt_idx (gnt_idx)
   );

   // granted slot picks the descriptor index
   assign order_wr_en  = gnt_vld;
   assign order_wr_idx = tbl_idx[gnt_idx];

endmodule

`default_nettype wire

/* logic/ownership_tracker.sv */
/*
 * Watches the ownership bits and feeds the request-id FIFO.
 * Auto order sends rises through a serializer, lowest index first for
 * same-cycle rises. Software order keeps pending bits and issues the
 * descriptor at the head of the order FIFO once it is pending.
 */

`default_nettype none

module ownership_tracker #(
   parameter int max_desc = desc_pkg::default_max_desc
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic [max_desc-1:0]                        owner,
   input  logic                                       auto_mode,
   input  logic [desc_pkg::desc_idx_w(max_desc)-1:0]  order_head,
   input  logic                                       order_head_valid,
   output logic                                       order_rd_en,
   output logic                                       id_wr_en,
   output logic [desc_pkg::desc_idx_w(max_desc)-1:0]  id_wr_idx
);
   import desc_pkg::*;

   localparam int iw = desc_idx_w(max_desc);

   logic [max_desc-1:0]   owner_q;
   logic [max_desc-1:0]   rise;
   logic [max_desc-1:0]   auto_req;
   logic [max_desc-1:0]   pend;
   logic [max_desc-1:0]   pend_nxt;
   logic                  sw_hit;
   logic                  gnt_vld;
   logic [iw-1:0]         gnt_idx;

   //////////////////////////////
   // ownership rise detect
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         owner_q <= '0;
      end else begin
         owner_q <= owner;
      end
   end

   assign rise = owner & ~owner_q;

   //////////////////////////////
   // auto order path
   //////////////////////////////

   assign auto_req = auto_mode ? rise : '0;

   grant_serializer #(
      .max_desc (max_desc)
   ) u_auto_ser (
      .clk     (clk),
      .resetn  (resetn),
      .req     (auto_req),
      .gnt_vld (gnt_vld),
      .gnt_idx (gnt_idx)
   );

   //////////////////////////////
   // software order path
   //////////////////////////////

   // head of order FIFO already owned
   assign sw_hit = ~auto_mode & order_head_valid & pend[order_head];

   always_comb begin
      pend_nxt = pend;
      if (sw_hit) begin
         pend_nxt[order_head] = 1'b0;
      end
      if (!auto_mode) begin
         pend_nxt = pend_nxt | rise;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         pend <= '0;
      end else begin
         pend <= pend_nxt;
      end
   end

   // issue source follows the mode
   assign order_rd_en = sw_hit;
   assign id_wr_en    = auto_mode ? gnt_vld : sw_hit;
   assign id_wr_idx   = auto_mode ? gnt_idx : order_head;

endmodule

`default_nettype wire

/* logic/fetch_fsm.sv */
/*
 * Fetch FSM for the request-id FIFO.
 * Pops one id when the FIFO has data and no allocation is running,
 * then holds off until the address handshake (aznext) is seen.
 * request_en doubles as the FIFO read enable.
 */

`default_nettype none

module fetch_fsm (
   input  logic   clk,
   input  logic   resetn,
   input  logic   id_empty,
   input  logic   desc_allocation_in_progress,
   input  logic   aznext,
   output logic   request_en
);
   import desc_pkg::*;

   fetch_state_t state;

   //////////////////////////////
   // state and pop pulse
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state      <= fetch_idle;
         request_en <= 1'b0;
      end else begin
         // single cycle pulse per fetch
         request_en <= 1'b0;
         case (state)
            fetch_idle: begin
               // pop only with data and no allocation busy
               if (!id_empty && !desc_allocation_in_progress) begin
                  request_en <= 1'b1;
                  state      <= fetch_read;
               end
            end
            fetch_read: begin
               // wait for address channel to take it
               if (aznext) begin
                  state <= fetch_idle;
               end
            end
            default: state <= fetch_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/desc_gen_top.sv */
/*
 * Descriptor request generator top level.
 * Software programs the order table over Wishbone and hands over
 * descriptors with the owner bits. Queued ids leave on request_id,
 * valid the cycle after each request_en pulse.
 */

`default_nettype none

module desc_gen_top #(
   parameter int max_desc = desc_pkg::default_max_desc
) (
   input  logic                                       clk,
   input  logic                                       resetn,
   input  logic                                       wb_cyc,
   input  logic                                       wb_stb,
   input  logic                                       wb_we,
   input  logic [wb_regs_pkg::wb_adr_w-1:0]           wb_adr,
   input  wb_regs_pkg::reg_word_u                     wb_dat_w,
   output wb_regs_pkg::reg_word_u                     wb_dat_r,
   output logic                                       wb_ack,
   input  logic [max_desc-1:0]                        owner,
   input  logic                                       desc_allocation_in_progress,
   input  logic                                       aznext,
   output logic                                       request_en,
   output logic [desc_pkg::desc_idx_w(max_desc)-1:0]  request_id
);
   import desc_pkg::*;

   localparam int iw = desc_idx_w(max_desc);

   logic            auto_mode;
   logic            order_wr_en;
   logic [iw-1:0]   order_wr_idx;
   logic            order_rd_en;
   logic [iw-1:0]   order_head;
   logic            order_head_valid;
   logic            id_wr_en;
   logic [iw-1:0]   id_wr_idx;
   logic            id_empty;

   //////////////////////////////
   // register block
   //////////////////////////////

   order_regs #(.max_desc (max_desc)) u_regs (
      .clk (clk), .resetn (resetn),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
      .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .auto_mode (auto_mode), .order_wr_en (order_wr_en), .order_wr_idx (order_wr_idx)
   );

   // software order queue
   desc_fifo #(.max_desc (max_desc), .depth (max_desc)) u_order_fifo (
      .clk (clk), .resetn (resetn),
      .wr_en (order_wr_en), .wr_data (order_wr_idx), .rd_en (order_rd_en),
      .rd_data (), .head (order_head), .head_valid (order_head_valid), .empty ()
   );

   //////////////////////////////
   // issue path
   //////////////////////////////

   ownership_tracker #(.max_desc (max_desc)) u_tracker (
      .clk (clk), .resetn (resetn), .owner (owner), .auto_mode (auto_mode),
      .order_head (order_head), .order_head_valid (order_head_valid),
      .order_rd_en (order_rd_en), .id_wr_en (id_wr_en), .id_wr_idx (id_wr_idx)
   );

   // ids waiting for the bus side
   desc_fifo #(.max_desc (max_desc), .depth (max_desc)) u_id_fifo (
      .clk (clk), .resetn (resetn),
      .wr_en (id_wr_en), .wr_data (id_wr_idx), .rd_en (request_en),
      .rd_data (request_id), .head (), .head_valid (), .empty (id_empty)
   );

   fetch_fsm u_fetch (
      .clk (clk), .resetn (resetn), .id_empty (id_empty),
      .desc_allocation_in_progress (desc_allocation_in_progress),
      .aznext (aznext), .request_en (request_en)
   );

endmodule

`default_nettype wire

/* testbench/tb_desc_gen.sv */
/*
 * Self-checking testbench for the descriptor request generator.
 * Tests come from desc_gen_input.txt, one per line. Each test programs
 * the order table over Wishbone, raises owner bits in steps and compares
 * the issued request_id sequence with the expected one. A bus-side
 * process answers request_en with aznext after 0 to 3 cycles.
 */

`default_nettype none

module tb_desc_gen;
   import desc_pkg::*;
   import wb_regs_pkg::*;

   localparam int max_desc  = default_max_desc;
   localparam int iw        = desc_idx_w(max_desc);
   localparam int max_tests = 16;
   localparam int quiet_cyc = 16;

   logic                  clk = 1'b0;
   logic                  resetn;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [wb_adr_w-1:0]   wb_adr;
   reg_word_u             wb_dat_w;
   reg_word_u             wb_dat_r;
   logic                  wb_ack;
   logic [max_desc-1:0]   owner;
   logic                  desc_allocation_in_progress;
   logic                  aznext = 1'b0;
   logic                  request_en;
   logic [iw-1:0]         request_id;

   // one slot per test line
   logic [8*24-1:0]  t_name  [max_tests];
   int               t_mode  [max_tests];
   logic [7:0]       t_ent   [max_tests][max_desc];
   int               t_nstep [max_tests];
   logic [7:0]       t_mask  [max_tests][4];
   int               t_gap   [max_tests][4];
   int               t_bp    [max_tests];
   int               t_nexp  [max_tests];
   int               t_exp   [max_tests][max_desc];
   int               n_tests = 0;
   logic             loaded = 1'b0;

   logic [8*24-1:0]  cur_name;
   int               test_errs;
   int               n_pass = 0;
   int               n_fail = 0;
   logic             hold_az;
   logic [iw-1:0]    seen_ids [$];
   int               pulse_cnt = 0;
   logic             req_q = 1'b0;
   logic [31:0]      lcg_state = 32'd11739;
   int               az_delay;

   desc_gen_top #(.max_desc (max_desc)) dut0 (
      .clk (clk), .resetn (resetn),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .owner (owner), .desc_allocation_in_progress (desc_allocation_in_progress),
      .aznext (aznext), .request_en (request_en), .request_id (request_id)
   );

   always #2 clk = ~clk;

   ////////////////////////////////
   // monitor and bus side
   ////////////////////////////////

   // request_id holds from the cycle after each pulse
   always @(posedge clk) begin
      if (req_q) begin
         seen_ids.push_back(request_id);
      end
      if (request_en === 1'b1) begin
         pulse_cnt = pulse_cnt + 1;
      end
      req_q = (request_en === 1'b1);
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // address handshake after a random delay
   // hold_az keeps it back
   always begin
      @(negedge clk);
      if (request_en === 1'b1) begin
         lcg_state = lcg_step(lcg_state);
         az_delay = int'(lcg_state[17:16]);
         repeat (az_delay) @(negedge clk);
         while (hold_az) begin
            @(negedge clk);
         end
         aznext = 1'b1;
         @(negedge clk);
         aznext = 1'b0;
      end
   end

   ////////////////////////////////
   // helpers
   ////////////////////////////////

   task automatic report_mismatch(input string what, input int expected, input int actual);
      $display("Mismatch in %0s: %0s expected %0d, actual %0d", cur_name, what, expected, actual);
      test_errs++;
   endtask

   task automatic apply_reset();
      resetn = 1'b0;
      repeat (4) @(negedge clk);
      resetn = 1'b1;
   endtask

   // one classic cycle
   // strobe stays up through the edge that ends the ack
   task automatic wb_access(input logic we, input logic [wb_adr_w-1:0] adr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
      int waited;
      waited = 0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = wdata;
      @(negedge clk);
      while (!wb_ack && waited < 8) begin
         @(negedge clk);
         waited++;
      end
      rdata = wb_dat_r;
      if (!wb_ack) begin
         $display("Error in %0s: no ack for access at address %0d", cur_name, adr);
         test_errs++;
      end
      @(negedge clk);
      if (wb_ack) begin
         $display("Error in %0s: ack held longer than one cycle", cur_name);
         test_errs++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic finish_test();
      if (test_errs == 0) begin
         n_pass++;
         $display("pass  %0s", cur_name);
      end else begin
         n_fail++;
         $display("fail  %0s with %0d errors", cur_name, test_errs);
      end
   endtask

   task automatic load_tests();
      int fd;
      int r;
      int c;
      logic [8*24-1:0] tok;
      fd = $fopen("testbench/desc_gen_input.txt", "r");
      if (fd == 0) begin
         $display("Error: the stimulus file could not be opened");
         return;
      end
      r = $fscanf(fd, "%s", tok);
      while (r == 1 && n_tests < max_tests) begin
         if (tok == "#") begin
            // skip the rest of a comment line
            c = $fgetc(fd);
            while (c != 10 && c != -1) begin
               c = $fgetc(fd);
            end
         end else begin
            t_name[n_tests] = tok;
            r = $fscanf(fd,
               "%d %h %h %h %h %h %h %h %h %d %h %d %h %d %h %d %h %d %d %d %d %d %d %d %d %d %d %d",
               t_mode[n_tests], t_ent[n_tests][0], t_ent[n_tests][1], t_ent[n_tests][2],
               t_ent[n_tests][3], t_ent[n_tests][4], t_ent[n_tests][5], t_ent[n_tests][6],
               t_ent[n_tests][7], t_nstep[n_tests],
               t_mask[n_tests][0], t_gap[n_tests][0], t_mask[n_tests][1], t_gap[n_tests][1],
               t_mask[n_tests][2], t_gap[n_tests][2], t_mask[n_tests][3], t_gap[n_tests][3],
               t_bp[n_tests], t_nexp[n_tests],
               t_exp[n_tests][0], t_exp[n_tests][1], t_exp[n_tests][2], t_exp[n_tests][3],
               t_exp[n_tests][4], t_exp[n_tests][5], t_exp[n_tests][6], t_exp[n_tests][7]);
            if (r != 28) begin
               $display("Error: test line %0d of the stimulus file is malformed", n_tests);
               n_fail++;
               break;
            end
            n_tests++;
         end
         r = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
   endtask

   ////////////////////////////////
   // tests
   ////////////////////////////////

   // no fetch, empty table and software order after reset
   task automatic run_reset_test();
      logic [7:0] rd;
      int base;
      cur_name = "reset";
      test_errs = 0;
      apply_reset();
      base = pulse_cnt;
      repeat (20) @(negedge clk);
      if (pulse_cnt != base) begin
         report_mismatch("request_en pulses", 0, pulse_cnt - base);
      end
      for (int i = 0; i < max_desc; i++) begin
         wb_access(1'b0, wb_adr_w'(i), 8'h00, rd);
         if (rd != 8'h00) begin
            report_mismatch("table entry after reset", 0, int'(rd));
         end
      end
      wb_access(1'b0, reg_ctrl_adr, 8'h00, rd);
      if (rd != 8'h00) begin
         report_mismatch("control after reset", 0, int'(rd));
      end
      finish_test();
   endtask

   task automatic run_test(input int t);
      logic [7:0] rd;
      logic [7:0] ctrl;
      int base_pulse;
      int base_ids;
      int got;
      int waited;
      cur_name = t_name[t];
      test_errs = 0;
      owner = '0;
      apply_reset();
      desc_allocation_in_progress = (t_bp[t] != 0);
      hold_az = (t_bp[t] != 0);

      // table write and readback
      for (int i = 0; i < max_desc; i++) begin
         wb_access(1'b1, wb_adr_w'(i), t_ent[t][i], rd);
      end
      for (int i = 0; i < max_desc; i++) begin
         wb_access(1'b0, wb_adr_w'(i), 8'h00, rd);
         if (rd != t_ent[t][i]) begin
            report_mismatch("table entry readback", int'(t_ent[t][i]), int'(rd));
         end
      end
      // mode plus push
      // push itself reads back as zero
      ctrl = (t_mode[t] != 0) ? 8'h01 : 8'h00;
      wb_access(1'b1, reg_ctrl_adr, ctrl | 8'h02, rd);
      wb_access(1'b0, reg_ctrl_adr, 8'h00, rd);
      if (rd != ctrl) begin
         report_mismatch("control readback", int'(ctrl), int'(rd));
      end

      base_pulse = pulse_cnt;
      base_ids = seen_ids.size();
      for (int k = 0; k < t_nstep[t]; k++) begin
         owner = owner | t_mask[t][k];
         repeat (t_gap[t][k]) @(negedge clk);
      end

      if (t_bp[t] != 0) begin
         repeat (10) @(negedge clk);
         if (pulse_cnt != base_pulse) begin
            report_mismatch("pulses during allocation", 0, pulse_cnt - base_pulse);
         end
         desc_allocation_in_progress = 1'b0;
         repeat (10) @(negedge clk);
         if (pulse_cnt - base_pulse != 1) begin
            report_mismatch("pulses without aznext", 1, pulse_cnt - base_pulse);
         end
         hold_az = 1'b0;
      end

      waited = 0;
      while (seen_ids.size() - base_ids < t_nexp[t] && waited < 100) begin
         @(negedge clk);
         waited++;
      end
      if (seen_ids.size() - base_ids < t_nexp[t]) begin
         $display("Error in %0s: timed out waiting for the expected ids", cur_name);
         test_errs++;
      end
      // nothing further may be issued
      repeat (quiet_cyc) @(negedge clk);
      got = seen_ids.size() - base_ids;
      if (got != t_nexp[t]) begin
         report_mismatch("issued id count", t_nexp[t], got);
      end
      for (int k = 0; k < t_nexp[t] && k < got; k++) begin
         if (int'(seen_ids[base_ids + k]) != t_exp[t][k]) begin
            report_mismatch("request_id", t_exp[t][k], int'(seen_ids[base_ids + k]));
         end
      end
      owner = '0;
      finish_test();
   endtask

   initial begin
      resetn = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      owner = '0;
      desc_allocation_in_progress = 1'b0;
      hold_az = 1'b0;
      load_tests();
      loaded = 1'b1;
      run_reset_test();
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      $display("summary: %0d tests passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0 && n_tests > 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog allows 200 cycles per test
   initial begin
      wait (loaded);
      repeat ((n_tests + 1) * 200) @(posedge clk);
      $display("Error: watchdog expired before the tests completed");
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/desc_gen_input.txt */
# name mode(1=auto) entry0..entry7(hex) nsteps, then 4 x (owner mask hex, gap cycles)
# then backpressure(1=on) count of expected ids and 8 expected ids (unused ones are 0)
auto_same_cycle 1 00 00 00 00 00 00 00 00 1 ff 2 00 0 00 0 00 0 0 8 0 1 2 3 4 5 6 7
auto_staggered 1 00 00 00 00 00 00 00 00 4 20 3 04 3 80 3 01 3 0 4 5 2 7 0 0 0 0 0
auto_pairs 1 83 02 81 00 00 00 00 00 2 30 3 03 3 00 0 00 0 0 4 4 5 0 1 0 0 0 0
sw_permutation 0 85 82 87 80 84 81 86 83 1 ff 2 00 0 00 0 00 0 0 8 5 2 7 0 4 1 6 3
sw_partial_table 0 86 00 81 83 00 00 00 00 1 4b 2 00 0 00 0 00 0 0 3 6 1 3 0 0 0 0 0
sw_stalled_head 0 83 81 80 82 00 00 00 00 4 01 4 04 4 08 4 02 4 0 4 3 1 0 2 0 0 0 0
auto_backpressure 1 00 00 00 00 00 00 00 00 1 ff 2 00 0 00 0 00 0 1 8 0 1 2 3 4 5 6 7
sw_backpressure 0 87 86 85 84 83 82 81 80 1 ff 2 00 0 00 0 00 0 1 8 7 6 5 4 3 2 1 0

/* build.f */
logic/desc_pkg.sv
logic/wb_regs_pkg.sv
logic/grant_serializer.sv
logic/desc_fifo.sv
logic/order_regs.sv
logic/ownership_tracker.sv
logic/fetch_fsm.sv
logic/desc_gen_top.sv
testbench/tb_desc_gen.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run, success only when the pass line shows up
cd "$(dirname "$0")" \
   && verilator --binary --timing -j 0 --top-module tb_desc_gen -f build.f \
   && ./obj_dir/Vtb_desc_gen | tee /dev/stderr | grep -qx "TEST OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
